// File: tb.f
+incdir+.
fetch_pkg.sv
mem_bus_if.sv
fetch_stage.sv
exec_unit.sv
mem_arbiter.sv
unified_memory.sv
fetch_top.sv
tb_clock.sv
tb_fetch.sv

// File: Makefile
TOOL     = verilator
FLAGS    = --timing --assert
TOP      = tb_fetch
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(TOOL) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_fetch.sv
// fetch front end testbench
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module tb_fetch;

	localparam int RETIRE_TIMEOUT = 40; // cycles allowed between two retires
	localparam int RESET_CYCLES   = 10;

	logic               clock;
	logic               por_reset;  // from the clock module
	logic               hold_reset; // preload and mid-run reset
	logic               dut_reset;
	logic               load_en;
	fetch_pkg::addr_t   load_addr;
	fetch_pkg::word_t   load_data;
	logic               retire_valid;
	fetch_pkg::addr_t   retire_pc;
	fetch_pkg::opcode_t retire_opcode;
	fetch_pkg::word_t   retire_data;

	fetch_pkg::word_t   img [0:`MEM_DEPTH-1]; // mirror of the DUT memory
	fetch_pkg::addr_t   model_pc;             // reference model pc
	fetch_pkg::addr_t   exp_pc;
	fetch_pkg::opcode_t exp_op;
	fetch_pkg::word_t   exp_data;

	assign dut_reset = por_reset | hold_reset;

	tb_clock i_clock (.clock, .reset(por_reset));

	fetch_top i_dut (.clock, .reset(dut_reset), .load_en, .load_addr, .load_data,
		.retire_valid, .retire_pc, .retire_opcode, .retire_data);

	////////////////////////////////////////
	// program building
	////////////////////////////////////////

	function automatic fetch_pkg::inst_t br_inst(input int disp); // word displacement
		return {`OP_BR, 5'd0, 21'(disp)};
	endfunction

	function automatic fetch_pkg::inst_t ld_inst(input int idx); // word index
		return {`OP_LDQ, 10'd0, 16'(idx)};
	endfunction

	// lower half a nop, upper half an unused opcode that also retires as a nop
	// the low bits carry the byte address
	task automatic fill_image();
		for (int i = 0; i < `MEM_DEPTH; i++)
			img[i] = {6'h3f, 26'(i * 8 + 4), `OP_NOP, 26'(i * 8)};
	endtask

	task automatic put_inst(input fetch_pkg::addr_t pc, input fetch_pkg::inst_t inst);
		if (pc[2])
			img[pc[10:3]][63:32] = inst; // upper half
		else
			img[pc[10:3]][31:0] = inst;
	endtask

	// whole image written under reset, then release
	task automatic load_image();
		@(posedge clock);
		hold_reset <= 1'b1;
		for (int i = 0; i < `MEM_DEPTH; i++)
		begin
			load_en   <= 1'b1;
			load_addr <= fetch_pkg::addr_t'(i * 8);
			load_data <= img[i];
			@(posedge clock);
		end
		load_en <= 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		hold_reset <= 1'b0;
	endtask

	task automatic apply_reset();
		@(posedge clock);
		hold_reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge clock);
		hold_reset <= 1'b0;
	endtask

	////////////////////////////////////////
	// reference model and checking
	////////////////////////////////////////

	task automatic check_equal(input string test, input string what,
		input fetch_pkg::word_t expected, input fetch_pkg::word_t actual);
		if (expected !== actual)
		begin
			$display("ERROR %s: %s expected %h actual %h", test, what, expected, actual);
			$display("Result: FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// one instruction of the program, in program order
	task automatic predict_retire();
		fetch_pkg::word_t word;
		fetch_pkg::inst_t inst;
		fetch_pkg::addr_t disp;
		word     = img[model_pc[10:3]];                        // index wraps at 256 words
		inst     = model_pc[2] ? word[63:32] : word[31:0];
		disp     = {{43{inst[20]}}, inst[20:0]};
		exp_pc   = model_pc;
		exp_op   = inst[31:26];
		exp_data = (exp_op == `OP_LDQ) ? img[inst[7:0]] : '0;  // load index modulo depth
		if (exp_op == `OP_BR)
			model_pc = model_pc + 64'd4 + disp * 64'd4;        // npc + 4 * disp
		else
			model_pc = model_pc + 64'd4;
	endtask

	task automatic wait_retire(input string test);
		int cycles;
		cycles = 0;
		@(negedge clock); // outputs settled
		while (!retire_valid && cycles < RETIRE_TIMEOUT)
		begin
			@(negedge clock);
			cycles++;
		end
		if (!retire_valid)
		begin
			$display("%s: no instruction retired within %0d cycles", test, RETIRE_TIMEOUT);
			$display("Result: FAILED");
			$fatal(1, "retire timeout");
		end
	endtask

	// retirement always restarts at pc 0 after reset
	task automatic run_program(input string test, input int count);
		model_pc = '0;
		for (int k = 0; k < count; k++)
		begin
			predict_retire();
			wait_retire(test);
			check_equal(test, "retire_pc", exp_pc, retire_pc);
			check_equal(test, "retire_opcode", fetch_pkg::word_t'(exp_op),
				fetch_pkg::word_t'(retire_opcode));
			check_equal(test, "retire_data", exp_data, retire_data);
		end
	endtask

	////////////////////////////////////////
	// directed tests
	////////////////////////////////////////

	task automatic nop_line_test();
		fill_image(); // nothing but instructions that retire as nops
		load_image();
		run_program("nop_line", 16);
	endtask

	task automatic branch_test();
		fill_image();
		put_inst(64'd4, br_inst(5));    // forward to 28
		put_inst(64'd8, ld_inst(200));  // shadow, never retires
		put_inst(64'd32, br_inst(-6));  // back to 12
		put_inst(64'd36, ld_inst(201)); // shadow too
		load_image();
		run_program("branches", 14);
	endtask

	task automatic load_test();
		int idx;
		fill_image();
		for (int i = 0; i < 8; i++)
		begin
			idx      = 64 + int'($urandom % 192); // above the program
			img[idx] = {$urandom, $urandom};
			put_inst(fetch_pkg::addr_t'(i * 4), ld_inst(idx));
		end
		load_image();
		run_program("loads", 8);
	endtask

	task automatic arbitration_test();
		int idx;
		fill_image();
		put_inst(64'd0, br_inst(3)); // to 16, load right at the target
		for (int i = 0; i < 4; i++)
		begin
			idx      = 64 + int'($urandom % 192);
			img[idx] = {$urandom, $urandom};
			put_inst(fetch_pkg::addr_t'(16 + i * 8), ld_inst(idx)); // nops in between
		end
		put_inst(64'd36, ld_inst(64)); // two loads back to back
		load_image();
		run_program("arbitration", 10);
	endtask

	task automatic other_opcode_test();
		fill_image();
		put_inst(64'd0, {6'd3, 26'h3ffffff});
		put_inst(64'd4, {6'd63, 26'($urandom)});
		for (int i = 2; i < 8; i++)
			put_inst(fetch_pkg::addr_t'(i * 4), {6'(3 + $urandom % 61), 26'($urandom)});
		load_image();
		run_program("other_opcodes", 9);
	endtask

	task automatic mid_reset_test();
		fill_image();
		img[70] = {$urandom, $urandom};
		put_inst(64'd0, ld_inst(70));
		put_inst(64'd8, br_inst(-3)); // loop back to 0
		load_image();
		run_program("mid_reset", 5);
		apply_reset();                // memory keeps the program
		run_program("mid_reset", 8);
	endtask

	initial
	begin
		hold_reset = 1'b1;
		load_en    = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		void'($urandom(32'h9501));
		nop_line_test();
		branch_test();
		load_test();
		arbitration_test();
		other_opcode_test();
		mid_reset_test();
		$display("Result: PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: tb_clock.sv
// testbench clock and reset
`timescale 1ns/100ps
`default_nettype none

module tb_clock
(
	output logic clock,
	output logic reset  // power-on reset, high for the first 10 cycles
);

	initial
	begin
		clock = 1'b0;
		reset = 1'b1;
		repeat (10) @(posedge clock);
		reset <= 1'b0;
	end

	always #50 clock = ~clock; // 100 ns period

endmodule

`default_nettype wire

// File: fetch_top.sv
// fetch front end top level
`timescale 1ns/100ps
`default_nettype none

module fetch_top
(
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   load_en,      // program preload write
	input  wire fetch_pkg::addr_t load_addr,
	input  wire fetch_pkg::word_t load_data,
	output logic                  retire_valid, // one pulse per instruction
	output fetch_pkg::addr_t      retire_pc,
	output fetch_pkg::opcode_t    retire_opcode,
	output fetch_pkg::word_t      retire_data
);

	mem_bus_if fetch_bus (); // fetch stage to arbiter
	mem_bus_if data_bus ();  // execute unit to arbiter

	// fetch to execute
	logic             if_valid_inst;
	fetch_pkg::inst_t if_inst;
	fetch_pkg::addr_t if_npc;

	// execute back to fetch
	logic             take_branch;
	fetch_pkg::addr_t target_pc;

	// arbiter to memory
	logic             mem_rd;
	fetch_pkg::addr_t mem_addr;
	fetch_pkg::word_t mem_rdata;

	fetch_stage i_fetch (.clock, .reset, .take_branch, .target_pc, .retire_valid,
		.bus(fetch_bus.requester), .if_valid_inst, .if_inst, .if_npc);

	exec_unit i_exec (.clock, .reset, .if_valid_inst, .if_inst, .if_npc,
		.bus(data_bus.requester), .take_branch, .target_pc,
		.retire_valid, .retire_pc, .retire_opcode, .retire_data);

	mem_arbiter i_arb (.clock, .reset, .fetch(fetch_bus.arbiter), .data(data_bus.arbiter),
		.mem_rd, .mem_addr, .mem_rdata);

	unified_memory i_mem (.clock, .rd(mem_rd), .rd_addr(mem_addr), .rdata(mem_rdata),
		.wr(load_en), .wr_addr(load_addr), .wdata(load_data));

endmodule

`default_nettype wire

// File: unified_memory.sv
// unified program and data memory
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module unified_memory
(
	input  wire                   clock,
	input  wire                   rd,      // read enable from the arbiter
	input  wire fetch_pkg::addr_t rd_addr, // byte address
	output fetch_pkg::word_t      rdata,   // one cycle after rd
	input  wire                   wr,      // preload only
	input  wire fetch_pkg::addr_t wr_addr,
	input  wire fetch_pkg::word_t wdata
);

	localparam int IDX_W = $clog2(`MEM_DEPTH); // word index bits

	fetch_pkg::word_t mem [0:`MEM_DEPTH-1];
	logic [IDX_W-1:0] rd_idx;
	logic [IDX_W-1:0] wr_idx;

	////////////////////////////////////////
	// address to word index
	////////////////////////////////////////

	// drop the byte offset, wrap at the depth
	assign rd_idx = rd_addr[IDX_W+2:3];
	assign wr_idx = wr_addr[IDX_W+2:3];

	////////////////////////////////////////
	// array
	////////////////////////////////////////

	// program and data written by the testbench
	always_ff @(posedge clock)
	begin
		if (wr)
			mem[wr_idx] <= wdata;
	end

	// registered read, holds between reads
	always_ff @(posedge clock)
	begin
		if (rd)
			rdata <= mem[rd_idx];
	end

	// both requesters hand over whole-word addresses
	a_rd_aligned: assert property (@(posedge clock)
		rd |-> (rd_addr[2:0] == 3'b000));

endmodule

`default_nettype wire

// File: mem_arbiter.sv
// fixed priority memory arbiter
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter
(
	input  wire                   clock,
	input  wire                   reset,
	mem_bus_if.arbiter            fetch,     // low priority
	mem_bus_if.arbiter            data,      // high priority
	output logic                  mem_rd,    // memory read enable
	output fetch_pkg::addr_t      mem_addr,
	input  wire fetch_pkg::word_t mem_rdata  // one cycle after mem_rd
);

	logic gnt_q;      // access in the memory this cycle
	logic gnt_data_q; // owner of that access, 1 = data
	logic rsp_q;      // response due this cycle
	logic rsp_data_q;
	logic busy;       // an access is outstanding
	logic grant;

	////////////////////////////////////////
	// grant
	////////////////////////////////////////

	// no new grant until the current response is out
	assign busy  = gnt_q | rsp_q;
	assign grant = (data.req | fetch.req) & ~busy;

	always_ff @(posedge clock)
	begin
		if (reset)
		begin
			gnt_q      <= 1'b0;
			gnt_data_q <= 1'b0;
			rsp_q      <= 1'b0;
			rsp_data_q <= 1'b0;
		end
		else
		begin
			gnt_q <= grant;
			if (grant)
				gnt_data_q <= data.req; // data wins a tie
			rsp_q      <= gnt_q;      // memory has one cycle latency
			rsp_data_q <= gnt_data_q;
		end
	end

	assign mem_rd   = gnt_q;
	assign mem_addr = gnt_data_q ? data.addr : fetch.addr; // owner still holds addr

	// valid pulse to the owner only
	assign fetch.valid = rsp_q & ~rsp_data_q;
	assign data.valid  = rsp_q & rsp_data_q;

	// read word to both sides
	assign fetch.rdata = mem_rdata;
	assign data.rdata  = mem_rdata;

	// the owner keeps its address until the memory has read it
	a_addr_held: assert property (@(posedge clock) disable iff (reset)
		grant |=> (gnt_data_q ? $stable(data.addr) : $stable(fetch.addr)));

	// a requester still holds its request when the word comes back
	a_fetch_req_held: assert property (@(posedge clock) disable iff (reset)
		fetch.valid |-> fetch.req);

	a_data_req_held: assert property (@(posedge clock) disable iff (reset)
		data.valid |-> data.req);

endmodule

`default_nettype wire

// File: exec_unit.sv
// execute unit for nop, branch and load
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module exec_unit
(
	input  wire                    clock,
	input  wire                    reset,
	input  wire                    if_valid_inst, // new instruction from fetch
	input  wire fetch_pkg::inst_t  if_inst,
	input  wire fetch_pkg::addr_t  if_npc,
	mem_bus_if.requester           bus,           // data side of the arbiter
	output logic                   take_branch,   // one-cycle pulse
	output fetch_pkg::addr_t       target_pc,
	output logic                   retire_valid,  // one-cycle pulse
	output fetch_pkg::addr_t       retire_pc,     // pc of the retired instruction
	output fetch_pkg::opcode_t     retire_opcode,
	output fetch_pkg::word_t       retire_data    // load word, else zero
);

	fetch_pkg::exec_state_t state;
	fetch_pkg::exec_state_t next_state;
	fetch_pkg::inst_t       inst_q; // instruction being executed
	fetch_pkg::addr_t       npc_q;  // its pc + 4
	fetch_pkg::opcode_t     opcode;
	logic                   is_branch;
	logic                   is_load;
	logic [`BR_DISP_W-1:0]  disp;   // signed word displacement
	logic [`LD_IDX_W-1:0]   ld_idx; // word index of a load

	////////////////////////////////////////
	// decode
	////////////////////////////////////////

	assign opcode    = inst_q[`INST_W-1:`INST_W-`OP_W];
	assign disp      = inst_q[`BR_DISP_W-1:0];
	assign ld_idx    = inst_q[`LD_IDX_W-1:0];
	assign is_branch = (opcode == `OP_BR);
	assign is_load   = (opcode == `OP_LDQ);

	// target = npc + 4 * disp, sign extended
	assign target_pc = npc_q + {{(`ADDR_W-`BR_DISP_W-2){disp[`BR_DISP_W-1]}}, disp, 2'b00};

	// capture on the fetch pulse, payload only
	always_ff @(posedge clock)
	begin
		if (if_valid_inst)
		begin
			inst_q <= if_inst;
			npc_q  <= if_npc;
		end
	end

	////////////////////////////////////////
	// state machine
	////////////////////////////////////////

	always_comb
	begin
		next_state = state;
		case (state)
			fetch_pkg::EX_IDLE:   if (if_valid_inst) next_state = fetch_pkg::EX_DECODE;
			fetch_pkg::EX_DECODE: next_state = is_load ? fetch_pkg::EX_LOAD : fetch_pkg::EX_IDLE;
			fetch_pkg::EX_LOAD:   if (bus.valid) next_state = fetch_pkg::EX_IDLE; // word is back
			default:              next_state = fetch_pkg::EX_IDLE;
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			state <= fetch_pkg::EX_IDLE;
		else
			state <= next_state;
	end

	// load request from decode until the word comes back
	assign bus.req  = ((state == fetch_pkg::EX_DECODE) & is_load) | (state == fetch_pkg::EX_LOAD);
	assign bus.addr = {{(`ADDR_W-`LD_IDX_W-3){1'b0}}, ld_idx, 3'b000}; // index * 8

	////////////////////////////////////////
	// retire
	////////////////////////////////////////

	assign take_branch  = (state == fetch_pkg::EX_DECODE) & is_branch;
	assign retire_valid = ((state == fetch_pkg::EX_DECODE) & ~is_load) |
	                      ((state == fetch_pkg::EX_LOAD) & bus.valid);
	assign retire_pc     = npc_q - fetch_pkg::addr_t'(4);
	assign retire_opcode = opcode;
	assign retire_data   = (state == fetch_pkg::EX_LOAD) ? bus.rdata : '0;

	// fetch must hold off until the previous instruction retired
	a_inst_when_idle: assert property (@(posedge clock) disable iff (reset)
		if_valid_inst |-> (state == fetch_pkg::EX_IDLE));

endmodule

`default_nettype wire

// File: fetch_stage.sv
// instruction fetch stage
`timescale 1ns/100ps
`default_nettype none

`include "fetch_defines.svh"

module fetch_stage
(
	input  wire                   clock,
	input  wire                   reset,
	input  wire                   take_branch,   // redirect from execute
	input  wire fetch_pkg::addr_t target_pc,     // used when take_branch is high
	input  wire                   retire_valid,  // previous instruction done
	mem_bus_if.requester          bus,           // fetch side of the arbiter
	output logic                  if_valid_inst, // one-cycle pulse
	output fetch_pkg::inst_t      if_inst,
	output fetch_pkg::addr_t      if_npc
);

	fetch_pkg::addr_t pc;         // pc being fetched
	fetch_pkg::addr_t pc_plus_4;
	fetch_pkg::addr_t next_pc;
	logic             pc_en;
	logic             ready;      // stall flag, high while waiting for an instruction
	logic             next_ready;

	////////////////////////////////////////
	// memory request
	////////////////////////////////////////

	// the stall flag is the request, word aligned address
	assign bus.req  = ready;
	assign bus.addr = {pc[`ADDR_W-1:3], 3'b000};

	// memory hands back 64 bits, pc bit 2 picks the half
	assign if_inst = pc[2] ? bus.rdata[`WORD_W-1:`INST_W] : bus.rdata[`INST_W-1:0];

	assign if_valid_inst = ready & bus.valid; // only a response we asked for

	////////////////////////////////////////
	// next pc
	////////////////////////////////////////

	assign pc_plus_4 = pc + fetch_pkg::addr_t'(4);
	assign if_npc    = pc_plus_4; // travels with the instruction

	// a taken branch wins over sequential flow, and over the stall
	assign next_pc = take_branch ? target_pc : pc_plus_4;
	assign pc_en   = if_valid_inst | take_branch;

	// wait again after each fetch until retire comes back
	assign next_ready = (ready | retire_valid) & ~if_valid_inst;

	always_ff @(posedge clock)
	begin
		if (reset)
			pc <= '0;              // start at address 0
		else if (pc_en)
			pc <= next_pc;
	end

	always_ff @(posedge clock)
	begin
		if (reset)
			ready <= 1'b1;         // ready to fetch straight out of reset
		else
			ready <= next_ready;
	end

	// the arbiter only answers fetch while the stage is waiting
	a_rsp_when_ready: assert property (@(posedge clock) disable iff (reset)
		bus.valid |-> ready);

endmodule

`default_nettype wire

// File: mem_bus_if.sv
// memory request bus
`timescale 1ns/100ps
`default_nettype none

// one requester, one arbiter port
// req and addr stay put until valid comes back
interface mem_bus_if;

	logic             req;   // request level
	fetch_pkg::addr_t addr;  // 8-byte aligned
	fetch_pkg::word_t rdata; // read word, good with valid
	logic             valid; // one-cycle response pulse

	// fetch stage or execute unit side
	modport requester
	(
		output req,
		output addr,
		input  rdata,
		input  valid
	);

	// arbiter side
	modport arbiter
	(
		input  req,
		input  addr,
		output rdata,
		output valid
	);

endinterface

`default_nettype wire

// File: fetch_pkg.sv
// fetch front end types
`default_nettype none

`include "fetch_defines.svh"

package fetch_pkg;

	////////////////////////////////////////
	// vector types
	////////////////////////////////////////

	typedef logic [`ADDR_W-1:0] addr_t;   // byte address or pc
	typedef logic [`WORD_W-1:0] word_t;   // one memory word
	typedef logic [`INST_W-1:0] inst_t;   // one instruction
	typedef logic [`OP_W-1:0]   opcode_t; // opcode field

	////////////////////////////////////////
	// execute unit states
	////////////////////////////////////////

	// idle waits for fetch, decode runs one cycle,
	// load waits on the data side of the memory bus
	typedef enum logic [1:0]
	{
		EX_IDLE   = 2'd0,
		EX_DECODE = 2'd1,
		EX_LOAD   = 2'd2
	} exec_state_t;

endpackage

`default_nettype wire

// File: fetch_defines.svh
// fetch front end parameters
`ifndef FETCH_DEFINES_SVH
`define FETCH_DEFINES_SVH

// datapath widths
`define ADDR_W    64 // pc and byte address
`define WORD_W    64 // memory word
`define INST_W    32 // one instruction, half a word
`define OP_W      6  // opcode field, bits 31..26

// memory size in 64-bit words
`define MEM_DEPTH 256

// instruction fields
`define BR_DISP_W 21 // signed word displacement, bits 20..0
`define LD_IDX_W  16 // unsigned word index, bits 15..0

// opcodes, anything else retires as a nop
`define OP_NOP    6'd0
`define OP_BR     6'd1
`define OP_LDQ    6'd2

`endif
